//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module eeprom_multi_tb -o eeprom_sim
	./obj_dir/eeprom_sim | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir

//--- eeprom_collect.sv
`include "eeprom_consts.svh"

module eeprom_collect (
    input  logic                      CLK,
    input  logic                      RESET,
    eeprom_req_if.collect             res [`EEPROM_CHANNELS],
    output logic                      resp_valid,
    output logic [`EEPROM_CHAN_W-1:0] resp_chan,
    output eeprom_pkg::eeprom_op_e    resp_op,
    output logic [`EEPROM_DATA_W-1:0] resp_rdata,
    output logic                      resp_nack
);
    logic [`EEPROM_CHANNELS-1:0] done_vec;
    logic [`EEPROM_CHANNELS-1:0] nack_vec;
    logic [`EEPROM_CHANNELS-1:0] take_vec;
    logic [`EEPROM_CHANNELS-1:0] elig;
    eeprom_pkg::eeprom_op_e      op_arr [`EEPROM_CHANNELS];
    logic [`EEPROM_DATA_W-1:0]   rdata_arr [`EEPROM_CHANNELS];
    logic [`EEPROM_CHAN_W-1:0]   ptr;
    logic [`EEPROM_CHAN_W-1:0]   pick;
    logic                        pick_hit;

    for (genvar i = 0; i < `EEPROM_CHANNELS; i++) begin : g_ch
        assign done_vec[i]  = res[i].done;
        assign nack_vec[i]  = res[i].nack;
        assign op_arr[i]    = res[i].res_op;
        assign rdata_arr[i] = res[i].rdata;
        assign res[i].take  = take_vec[i];
    end

    // done is still high in the take cycle
    assign elig = done_vec & ~take_vec;

    // first eligible channel at or after ptr
    always_comb begin
        int idx;
        pick_hit = 1'b0;
        pick     = ptr;
        for (int k = 0; k < `EEPROM_CHANNELS; k++) begin
            idx = (int'(ptr) + k) % `EEPROM_CHANNELS;
            if (!pick_hit && elig[idx]) begin
                pick_hit = 1'b1;
                pick     = `EEPROM_CHAN_W'(idx);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            resp_valid <= 1'b0;
            take_vec   <= '0;
            ptr        <= '0;
        end else begin
            resp_valid <= pick_hit;
            take_vec   <= pick_hit ? (`EEPROM_CHANNELS'(1) << pick) : '0;
            if (pick_hit)
                ptr <= (pick == `EEPROM_CHAN_W'(`EEPROM_CHANNELS - 1)) ? '0 : pick + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (pick_hit) begin
            resp_chan  <= pick;
            resp_op    <= op_arr[pick];
            resp_rdata <= rdata_arr[pick];
            resp_nack  <= nack_vec[pick];
        end
    end

endmodule

//--- eeprom_consts.svh
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// two independent I2C buses
`define EEPROM_CHANNELS 2
`define EEPROM_CHAN_W   1

// 24C16: 2 KB, 11-bit byte address
`define EEPROM_ADDR_W   11
`define EEPROM_DATA_W   8

// CLK cycles per quarter SCL bit
`define EEPROM_QTR_CLKS 4

// upper nibble of the control byte
`define EEPROM_DEV_CODE 4'b1010

`endif

//--- eeprom_dispatch.sv
`include "eeprom_consts.svh"

module eeprom_dispatch (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      wr,
    input  logic                      rd,
    input  logic [`EEPROM_CHAN_W-1:0] chan,
    input  logic [`EEPROM_ADDR_W-1:0] addr,
    input  logic [`EEPROM_DATA_W-1:0] wdata,
    output logic                      drop,
    eeprom_req_if.dispatch            req [`EEPROM_CHANNELS]
);
    logic                        pend;
    eeprom_pkg::eeprom_op_e      pend_op;
    logic [`EEPROM_CHAN_W-1:0]   pend_chan;
    logic [`EEPROM_ADDR_W-1:0]   pend_addr;
    logic [`EEPROM_DATA_W-1:0]   pend_wdata;
    logic [`EEPROM_CHANNELS-1:0] busy_vec;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pend <= 1'b0;
        end else begin
            pend <= wr | rd;
        end
    end

    // request payload, wr wins over rd
    always_ff @(posedge CLK) begin
        if (wr | rd) begin
            pend_op    <= wr ? eeprom_pkg::OP_WRITE : eeprom_pkg::OP_READ;
            pend_chan  <= chan;
            pend_addr  <= addr;
            pend_wdata <= wdata;
        end
    end

    // busy is tested one cycle late so a start issued last cycle is seen
    for (genvar i = 0; i < `EEPROM_CHANNELS; i++) begin : g_ch
        assign busy_vec[i]  = req[i].busy;
        assign req[i].start = pend && (pend_chan == `EEPROM_CHAN_W'(i)) && !req[i].busy;
        assign req[i].op    = pend_op;
        assign req[i].addr  = pend_addr;
        assign req[i].wdata = pend_wdata;
    end

    assign drop = pend && busy_vec[pend_chan];   // engine still working

endmodule

//--- eeprom_engine.sv
`include "eeprom_consts.svh"

module eeprom_engine (
    input  logic         CLK,
    input  logic         RESET,
    eeprom_req_if.engine req,
    output logic         scl,
    output logic         sda_oe,
    input  logic         sda_in
);
    localparam int QW = $clog2(`EEPROM_QTR_CLKS);

    eeprom_pkg::eeprom_state_e state;
    eeprom_pkg::eeprom_bit_e   phase;
    logic [QW-1:0]             qcnt;
    logic [3:0]                bitcnt;
    logic                      nack_r;
    logic [`EEPROM_DATA_W-1:0] shreg;
    logic [`EEPROM_DATA_W-1:0] rdata_r;
    eeprom_pkg::eeprom_op_e    op_r;
    logic [`EEPROM_ADDR_W-1:0] addr_r;
    logic [`EEPROM_DATA_W-1:0] wdata_r;
    logic [`EEPROM_DATA_W-1:0] ctrl_wr;
    logic [`EEPROM_DATA_W-1:0] ctrl_rd;
    logic                      running;
    logic                      tick;
    logic                      sample;
    logic                      bit_end;
    logic                      ack_slot;
    logic                      slave_ack;

    // block select bits ride in the control byte
    assign ctrl_wr = {`EEPROM_DEV_CODE, addr_r[`EEPROM_ADDR_W-1:8], 1'b0};
    assign ctrl_rd = {`EEPROM_DEV_CODE, addr_r[`EEPROM_ADDR_W-1:8], 1'b1};

    assign running  = (state != eeprom_pkg::ST_IDLE) && (state != eeprom_pkg::ST_DONE);
    assign tick     = (qcnt == QW'(`EEPROM_QTR_CLKS - 1));
    assign sample   = tick && (phase == eeprom_pkg::Q_HIGH_SAMPLE);
    assign bit_end  = tick && (phase == eeprom_pkg::Q_FALL);
    assign ack_slot = (bitcnt == 4'(`EEPROM_DATA_W));   // ninth bit of a byte

    assign slave_ack = (state == eeprom_pkg::ST_CTRL_W) || (state == eeprom_pkg::ST_ADDR) ||
                       (state == eeprom_pkg::ST_DATA_W) || (state == eeprom_pkg::ST_CTRL_R);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state  <= eeprom_pkg::ST_IDLE;
            phase  <= eeprom_pkg::Q_LOW_SET;
            qcnt   <= '0;
            bitcnt <= '0;
            nack_r <= 1'b0;
        end else begin
            if (running) begin
                if (tick) begin
                    qcnt  <= '0;
                    phase <= eeprom_pkg::eeprom_bit_e'(phase + 2'd1);
                end else begin
                    qcnt <= qcnt + 1'b1;
                end
            end

            if (sample && ack_slot && slave_ack && sda_in)
                nack_r <= 1'b1;                          // nobody pulled SDA
            if (sample && !ack_slot && (state == eeprom_pkg::ST_DATA_R))
                shreg <= {shreg[`EEPROM_DATA_W-2:0], sda_in};

            case (state)
                eeprom_pkg::ST_IDLE: begin
                    if (req.start) begin
                        op_r    <= req.op;
                        addr_r  <= req.addr;
                        wdata_r <= req.wdata;
                        rdata_r <= '0;                   // writes report zero
                        nack_r  <= 1'b0;
                        state   <= eeprom_pkg::ST_START;
                    end
                end
                eeprom_pkg::ST_START: begin
                    if (bit_end) begin
                        shreg <= ctrl_wr;
                        state <= eeprom_pkg::ST_CTRL_W;
                    end
                end
                eeprom_pkg::ST_RESTART: begin
                    if (bit_end) begin
                        shreg <= ctrl_rd;
                        state <= eeprom_pkg::ST_CTRL_R;
                    end
                end
                eeprom_pkg::ST_STOP: begin
                    if (bit_end)
                        state <= eeprom_pkg::ST_DONE;
                end
                eeprom_pkg::ST_DONE: begin
                    if (req.take)
                        state <= eeprom_pkg::ST_IDLE;
                end
                default: begin
                    // byte phases: 8 data bits then the ack slot
                    if (bit_end && !ack_slot) begin
                        bitcnt <= bitcnt + 4'd1;
                        if (state != eeprom_pkg::ST_DATA_R)
                            shreg <= {shreg[`EEPROM_DATA_W-2:0], 1'b0};
                    end else if (bit_end) begin
                        bitcnt <= '0;
                        if (nack_r) begin
                            state <= eeprom_pkg::ST_STOP;
                        end else begin
                            case (state)
                                eeprom_pkg::ST_CTRL_W: begin
                                    shreg <= addr_r[7:0];
                                    state <= eeprom_pkg::ST_ADDR;
                                end
                                eeprom_pkg::ST_ADDR: begin
                                    if (op_r == eeprom_pkg::OP_WRITE) begin
                                        shreg <= wdata_r;
                                        state <= eeprom_pkg::ST_DATA_W;
                                    end else begin
                                        state <= eeprom_pkg::ST_RESTART;
                                    end
                                end
                                eeprom_pkg::ST_CTRL_R: state <= eeprom_pkg::ST_DATA_R;
                                eeprom_pkg::ST_DATA_R: begin
                                    rdata_r <= shreg;
                                    state   <= eeprom_pkg::ST_STOP;
                                end
                                default: state <= eeprom_pkg::ST_STOP;
                            endcase
                        end
                    end
                end
            endcase
        end
    end

    // SCL: idle high, high for the middle two quarters, stays high in stop
    always_comb begin
        case (state)
            eeprom_pkg::ST_IDLE,
            eeprom_pkg::ST_DONE: scl = 1'b1;
            eeprom_pkg::ST_STOP: scl = (phase != eeprom_pkg::Q_LOW_SET);
            default:             scl = (phase == eeprom_pkg::Q_RISE) ||
                                       (phase == eeprom_pkg::Q_HIGH_SAMPLE);
        endcase
    end

    always_comb begin
        case (state)
            eeprom_pkg::ST_START,
            eeprom_pkg::ST_RESTART: sda_oe = (phase == eeprom_pkg::Q_HIGH_SAMPLE) ||
                                             (phase == eeprom_pkg::Q_FALL);   // falls with scl high
            eeprom_pkg::ST_STOP:    sda_oe = (phase == eeprom_pkg::Q_LOW_SET) ||
                                             (phase == eeprom_pkg::Q_RISE);   // rises with scl high
            eeprom_pkg::ST_CTRL_W,
            eeprom_pkg::ST_ADDR,
            eeprom_pkg::ST_DATA_W,
            eeprom_pkg::ST_CTRL_R:  sda_oe = !ack_slot && !shreg[`EEPROM_DATA_W-1];
            default:                sda_oe = 1'b0;   // read data and master nack
        endcase
    end

    assign req.busy   = (state != eeprom_pkg::ST_IDLE);
    assign req.done   = (state == eeprom_pkg::ST_DONE);
    assign req.res_op = op_r;
    assign req.rdata  = rdata_r;
    assign req.nack   = nack_r;

endmodule

//--- eeprom_model.sv
`include "eeprom_consts.svh"

// behavioral 24C16 slave, byte write and random read only
module eeprom_model (
    input  logic CLK,
    input  logic en,
    input  logic scl,
    input  logic sda,
    output logic pd
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`EEPROM_DATA_W-1:0] mem [2**`EEPROM_ADDR_W];
    logic [`EEPROM_DATA_W-1:0] sh;
    logic [`EEPROM_DATA_W-1:0] outb;
    logic [`EEPROM_ADDR_W-1:0] ptr;
    logic [3:0]                bitcnt;
    logic [1:0]                idx;
    logic                      active;
    logic                      sending;
    logic                      rd_pend;
    logic                      scl_q;
    logic                      sda_q;

    initial begin
        pd      = 1'b0;
        active  = 1'b0;
        sending = 1'b0;
        rd_pend = 1'b0;
        bitcnt  = '0;
        idx     = '0;
        ptr     = '0;
        scl_q   = 1'b1;
        sda_q   = 1'b1;
        for (int i = 0; i < 2**`EEPROM_ADDR_W; i++)
            mem[i] = 8'(i) ^ 8'(i >> 8);
    end

    always @(posedge CLK) begin
        scl_q <= scl;
        sda_q <= sda;
        if (!en) begin
            pd     <= 1'b0;
            active <= 1'b0;
        end else if (scl_q && scl && sda_q && !sda) begin
            active  <= 1'b1;        // start or repeated start
            sending <= 1'b0;
            rd_pend <= 1'b0;
            bitcnt  <= 4'd15;       // skip the fall that ends the start bit
            idx     <= '0;
            pd      <= 1'b0;
        end else if (scl_q && scl && !sda_q && sda) begin
            active <= 1'b0;         // stop
            pd     <= 1'b0;
        end else if (active && !scl_q && scl) begin
            if (bitcnt < 4'd8 && !sending)
                sh <= {sh[`EEPROM_DATA_W-2:0], sda};
        end else if (active && scl_q && !scl) begin
            if (bitcnt == 4'd15) begin
                bitcnt <= '0;
            end else if (bitcnt == 4'd8) begin
                bitcnt <= '0;
                pd     <= 1'b0;
                if (sending) begin
                    active  <= 1'b0;    // no sequential reads
                    sending <= 1'b0;
                end else if (rd_pend) begin
                    sending <= 1'b1;
                    rd_pend <= 1'b0;
                    pd      <= !outb[7];
                end
            end else if (sending) begin
                bitcnt <= bitcnt + 4'd1;
                pd     <= (bitcnt == 4'd7) ? 1'b0 : !outb[3'(6 - bitcnt)];
            end else if (bitcnt == 4'd7) begin
                bitcnt <= 4'd8;
                idx    <= idx + 2'd1;
                case (idx)
                    2'd0: begin
                        if (sh[7:4] == `EEPROM_DEV_CODE) begin
                            pd        <= 1'b1;
                            ptr[10:8] <= sh[3:1];
                            if (sh[0]) begin
                                outb    <= mem[{sh[3:1], ptr[7:0]}];
                                rd_pend <= 1'b1;
                            end
                        end else begin
                            active <= 1'b0;   // not addressed
                        end
                    end
                    2'd1: begin
                        ptr[7:0] <= sh;
                        pd       <= 1'b1;
                    end
                    default: begin
                        mem[ptr] <= sh;
                        pd       <= 1'b1;
                    end
                endcase
            end else begin
                bitcnt <= bitcnt + 4'd1;
            end
        end
    end

endmodule

//--- eeprom_multi.sv
`include "eeprom_consts.svh"

module eeprom_multi (
    input  logic                        CLK,
    input  logic                        RESET,
    // host side
    input  logic                        wr,
    input  logic                        rd,
    input  logic [`EEPROM_CHAN_W-1:0]   chan,
    input  logic [`EEPROM_ADDR_W-1:0]   addr,
    input  logic [`EEPROM_DATA_W-1:0]   wdata,
    output logic                        drop,
    output logic                        resp_valid,
    output logic [`EEPROM_CHAN_W-1:0]   resp_chan,
    output eeprom_pkg::eeprom_op_e      resp_op,
    output logic [`EEPROM_DATA_W-1:0]   resp_rdata,
    output logic                        resp_nack,
    output logic [`EEPROM_CHANNELS-1:0] busy_vec,
    // one I2C bus per channel
    output logic [`EEPROM_CHANNELS-1:0] scl,
    output logic [`EEPROM_CHANNELS-1:0] sda_oe,
    input  logic [`EEPROM_CHANNELS-1:0] sda_in
);
    eeprom_req_if req_if [`EEPROM_CHANNELS] ();

    eeprom_dispatch dispatch_inst (
        .CLK   (CLK),
        .RESET (RESET),
        .wr    (wr),
        .rd    (rd),
        .chan  (chan),
        .addr  (addr),
        .wdata (wdata),
        .drop  (drop),
        .req   (req_if)
    );

    for (genvar i = 0; i < `EEPROM_CHANNELS; i++) begin : g_eng
        eeprom_engine engine_inst (
            .CLK    (CLK),
            .RESET  (RESET),
            .req    (req_if[i]),
            .scl    (scl[i]),
            .sda_oe (sda_oe[i]),
            .sda_in (sda_in[i])
        );

        assign busy_vec[i] = req_if[i].busy;
    end

    eeprom_collect collect_inst (
        .CLK        (CLK),
        .RESET      (RESET),
        .res        (req_if),
        .resp_valid (resp_valid),
        .resp_chan  (resp_chan),
        .resp_op    (resp_op),
        .resp_rdata (resp_rdata),
        .resp_nack  (resp_nack)
    );

endmodule

//--- eeprom_multi_assert.sv
`include "eeprom_consts.svh"

module eeprom_multi_assert (
    input logic                        CLK,
    input logic                        RESET,
    input logic                        wr,
    input logic                        rd,
    input logic [`EEPROM_CHAN_W-1:0]   chan,
    input logic                        drop,
    input logic                        resp_valid,
    input logic [`EEPROM_CHAN_W-1:0]   resp_chan,
    input logic [`EEPROM_CHANNELS-1:0] busy_vec,
    input logic [`EEPROM_CHANNELS-1:0] scl,
    input logic [`EEPROM_CHANNELS-1:0] sda_oe
);
    timeunit 1ns;
    timeprecision 1ps;

    // start and stop move SDA in the middle of a high SCL, never on an edge
    for (genvar i = 0; i < `EEPROM_CHANNELS; i++) begin : g_bus
        sda_vs_scl: assert property (@(posedge CLK) disable iff (RESET)
            !$stable(sda_oe[i]) |-> $stable(scl[i]))
            else $error("sda_oe moved on an scl edge, channel %0d", i);
    end

    // back-to-back pulses are allowed only for different channels
    resp_one_cycle: assert property (@(posedge CLK) disable iff (RESET)
        resp_valid |=> !resp_valid || (resp_chan != $past(resp_chan)))
        else $error("resp_valid held longer than one cycle");

    drop_when_busy: assert property (@(posedge CLK) disable iff (RESET)
        drop |-> $past(wr || rd) && busy_vec[$past(chan)])
        else $error("drop without a busy channel");

    idle_after_reset: assert property (@(posedge CLK)
        $fell(RESET) |-> (scl == '1) && (sda_oe == '0) && (busy_vec == '0) &&
                         !resp_valid && !drop)
        else $error("outputs not idle after reset");

endmodule

bind eeprom_multi eeprom_multi_assert assert_inst (
    .CLK        (CLK),
    .RESET      (RESET),
    .wr         (wr),
    .rd         (rd),
    .chan       (chan),
    .drop       (drop),
    .resp_valid (resp_valid),
    .resp_chan  (resp_chan),
    .busy_vec   (busy_vec),
    .scl        (scl),
    .sda_oe     (sda_oe)
);

//--- eeprom_multi_tb.sv
`include "eeprom_consts.svh"

module eeprom_multi_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_REQ   = 15;
    localparam int N_WR    = 8;
    localparam int WR_WAIT = 200;   // write cycle, in CLK cycles
    localparam int LIMIT   = 2 * N_REQ * 48 * 4 * `EEPROM_QTR_CLKS + N_WR * WR_WAIT;

    logic                        CLK;
    logic                        RESET;
    logic                        wr;
    logic                        rd;
    logic [`EEPROM_CHAN_W-1:0]   chan;
    logic [`EEPROM_ADDR_W-1:0]   addr;
    logic [`EEPROM_DATA_W-1:0]   wdata;
    logic                        drop;
    logic                        resp_valid;
    logic [`EEPROM_CHAN_W-1:0]   resp_chan;
    eeprom_pkg::eeprom_op_e      resp_op;
    logic [`EEPROM_DATA_W-1:0]   resp_rdata;
    logic                        resp_nack;
    logic [`EEPROM_CHANNELS-1:0] busy_vec;
    logic [`EEPROM_CHANNELS-1:0] scl;
    logic [`EEPROM_CHANNELS-1:0] sda_oe;
    logic [`EEPROM_CHANNELS-1:0] sda_in;
    logic [`EEPROM_CHANNELS-1:0] pd;
    logic [`EEPROM_CHANNELS-1:0] model_en;

    logic [`EEPROM_DATA_W-1:0] sb [`EEPROM_CHANNELS][2**`EEPROM_ADDR_W];   // expected memory
    int seed = 57884;
    int test_errs;
    int n_pass;
    int n_fail;
    int cycles;

    eeprom_multi eeprom_multi_inst (.*);

    assign sda_in = ~(sda_oe | pd);   // wired-AND

    for (genvar i = 0; i < `EEPROM_CHANNELS; i++) begin : g_dev
        eeprom_model model_inst (
            .CLK (CLK),
            .en  (model_en[i]),
            .scl (scl[i]),
            .sda (sda_in[i]),
            .pd  (pd[i])
        );
    end

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("timeout: no finish after %0d cycles", LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [`EEPROM_ADDR_W-1:0] rand_addr();
        logic [31:0] r;
        r = $random(seed);
        return r[`EEPROM_ADDR_W-1:0];
    endfunction

    function automatic logic [`EEPROM_DATA_W-1:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[`EEPROM_DATA_W-1:0];
    endfunction

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            $display("Fail %0t: %s", $time, msg);
            test_errs++;
        end
    endtask

    task automatic strobe(input logic w, input logic [`EEPROM_CHAN_W-1:0] c,
                          input logic [`EEPROM_ADDR_W-1:0] a,
                          input logic [`EEPROM_DATA_W-1:0] d);
        @(posedge CLK);
        wr    <= w;
        rd    <= !w;
        chan  <= c;
        addr  <= a;
        wdata <= d;
    endtask

    task automatic release_strobes();
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic get_resp(output logic [`EEPROM_CHAN_W-1:0] c, output logic is_rd,
                            output logic [`EEPROM_DATA_W-1:0] q, output logic nk);
        do @(negedge CLK); while (!resp_valid);
        c     = resp_chan;
        is_rd = (resp_op == eeprom_pkg::OP_READ);
        q     = resp_rdata;
        nk    = resp_nack;
    endtask

    task automatic access(input logic w, input logic [`EEPROM_CHAN_W-1:0] c,
                          input logic [`EEPROM_ADDR_W-1:0] a,
                          input logic [`EEPROM_DATA_W-1:0] d,
                          output logic [`EEPROM_DATA_W-1:0] q, output logic nk);
        logic [`EEPROM_CHAN_W-1:0] rc;
        logic                      is_rd;
        strobe(w, c, a, d);
        release_strobes();
        @(negedge CLK);
        check(!drop, "request to an idle channel dropped");
        get_resp(rc, is_rd, q, nk);
        check(rc == c, $sformatf("resp_chan %0d, expected %0d", rc, c));
        check(is_rd == !w, "resp_op does not match the request");
        if (w)
            repeat (WR_WAIT) @(posedge CLK);
    endtask

    task automatic write_byte(input logic [`EEPROM_CHAN_W-1:0] c,
                              input logic [`EEPROM_ADDR_W-1:0] a,
                              input logic [`EEPROM_DATA_W-1:0] d);
        logic [`EEPROM_DATA_W-1:0] q;
        logic                      nk;
        access(1'b1, c, a, d, q, nk);
        check(!nk && q == '0, $sformatf("write ch%0d addr %h nack %b rdata %h", c, a, nk, q));
        sb[c][a] = d;
    endtask

    task automatic read_check(input logic [`EEPROM_CHAN_W-1:0] c,
                              input logic [`EEPROM_ADDR_W-1:0] a);
        logic [`EEPROM_DATA_W-1:0] q;
        logic                      nk;
        access(1'b0, c, a, '0, q, nk);
        check(!nk, $sformatf("read ch%0d addr %h got nack", c, a));
        check(q == sb[c][a], $sformatf("ch%0d addr %h read %h, expected %h", c, a, q, sb[c][a]));
    endtask

    task automatic check_idle();
        @(negedge CLK);
        check(scl == '1 && sda_oe == '0 && busy_vec == '0, "buses not idle");
    endtask

    task automatic end_test(input string name);
        $display("test %s: %s", name, (test_errs == 0) ? "ok" : $sformatf("%0d errors", test_errs));
        if (test_errs == 0)
            n_pass++;
        else
            n_fail++;
        test_errs = 0;
    endtask

    initial begin
        logic [`EEPROM_ADDR_W-1:0]   a [`EEPROM_CHANNELS];
        logic [`EEPROM_DATA_W-1:0]   d;
        logic [`EEPROM_DATA_W-1:0]   q;
        logic [`EEPROM_CHAN_W-1:0]   rc;
        logic                        is_rd;
        logic                        nk;
        logic [`EEPROM_CHANNELS-1:0] seen;
        CLK       = 1'b0;
        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        chan      = '0;
        addr      = '0;
        wdata     = '0;
        model_en  = '1;
        cycles    = 0;
        test_errs = 0;
        n_pass    = 0;
        n_fail    = 0;
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;

        check_idle();
        end_test("reset state");

        a[0] = rand_addr();
        write_byte(0, a[0], rand_byte());
        read_check(0, a[0]);
        check_idle();
        end_test("write then read");

        // back-to-back requests on both buses
        for (int c = 0; c < `EEPROM_CHANNELS; c++) begin
            a[c] = rand_addr();
            d    = rand_byte();
            strobe(1'b1, c[0], a[c], d);
            sb[c][a[c]] = d;
        end
        release_strobes();
        seen = '0;
        for (int k = 0; k < `EEPROM_CHANNELS; k++) begin
            get_resp(rc, is_rd, q, nk);
            check(!seen[rc], $sformatf("second write response from ch%0d", rc));
            seen[rc] = 1'b1;
            check(!nk && !is_rd, $sformatf("write response ch%0d nack %b", rc, nk));
        end
        repeat (WR_WAIT) @(posedge CLK);
        for (int c = 0; c < `EEPROM_CHANNELS; c++)
            strobe(1'b0, c[0], a[c], '0);
        release_strobes();
        seen = '0;
        for (int k = 0; k < `EEPROM_CHANNELS; k++) begin
            get_resp(rc, is_rd, q, nk);
            check(!seen[rc], $sformatf("second read response from ch%0d", rc));
            seen[rc] = 1'b1;
            check(!nk && is_rd && q == sb[rc][a[rc]],
                  $sformatf("ch%0d read %h, expected %h", rc, q, sb[rc][a[rc]]));
        end
        check_idle();
        end_test("concurrent traffic");

        a[0] = rand_addr();
        d    = rand_byte();
        strobe(1'b1, 0, a[0], d);
        release_strobes();
        do @(negedge CLK); while (!busy_vec[0]);
        strobe(1'b1, 0, a[0], ~d);
        release_strobes();
        @(negedge CLK);
        check(drop, "strobe to a busy channel was not dropped");
        get_resp(rc, is_rd, q, nk);
        check(rc == 0 && !nk, "first write did not complete");
        sb[0][a[0]] = d;
        repeat (WR_WAIT) @(posedge CLK);
        read_check(0, a[0]);
        end_test("busy rejection");

        model_en[1] = 1'b0;
        a[1] = rand_addr();
        access(1'b1, 1, a[1], rand_byte(), q, nk);
        check(nk, "write to an absent device not nacked");
        access(1'b0, 1, a[1], '0, q, nk);
        check(nk, "read from an absent device not nacked");
        check_idle();
        model_en[1] = 1'b1;
        end_test("absent device");

        a[0] = rand_addr() & 11'h3ff;
        d    = rand_byte();
        write_byte(0, a[0], d);
        write_byte(0, a[0] | 11'h400, ~d);
        read_check(0, a[0]);
        read_check(0, a[0] | 11'h400);
        check_idle();
        end_test("address mapping");

        $display("tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- eeprom_pkg.sv
package eeprom_pkg;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } eeprom_op_e;

    // engine phases, one per bus frame segment
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_CTRL_W,
        ST_ADDR,
        ST_DATA_W,
        ST_RESTART,
        ST_CTRL_R,
        ST_DATA_R,
        ST_STOP,
        ST_DONE
    } eeprom_state_e;

    // quarters of one SCL bit
    typedef enum logic [1:0] {
        Q_LOW_SET,
        Q_RISE,
        Q_HIGH_SAMPLE,
        Q_FALL
    } eeprom_bit_e;

endpackage

//--- eeprom_req_if.sv
`include "eeprom_consts.svh"

interface eeprom_req_if;
    // request side
    logic                      start;
    eeprom_pkg::eeprom_op_e    op;
    logic [`EEPROM_ADDR_W-1:0] addr;
    logic [`EEPROM_DATA_W-1:0] wdata;

    // result side, held while done
    logic                      busy;
    logic                      done;
    eeprom_pkg::eeprom_op_e    res_op;
    logic [`EEPROM_DATA_W-1:0] rdata;
    logic                      nack;
    logic                      take;

    modport dispatch (
        output start, op, addr, wdata,
        input  busy
    );

    modport engine (
        input  start, op, addr, wdata, take,
        output busy, done, res_op, rdata, nack
    );

    modport collect (
        input  done, res_op, rdata, nack,
        output take
    );
endinterface

//--- list.f
+incdir+.
eeprom_pkg.sv
eeprom_req_if.sv
eeprom_dispatch.sv
eeprom_engine.sv
eeprom_collect.sv
eeprom_multi.sv
eeprom_model.sv
eeprom_multi_assert.sv
eeprom_multi_tb.sv
